// File: sources.f
rtl/jt900h_pkg.sv
rtl/jt900h_ramctl.sv
rtl/jt900h_opbuf.sv
rtl/jt900h_idxaddr.sv
rtl/jt900h_idx_top.sv
sim/jt900h_prog_ram.sv
sim/jt900h_idx_tb.sv

// File: Bender.yml
package:
  name: jt900h_idx

sources:
  - files:
      - rtl/jt900h_pkg.sv
      - rtl/jt900h_ramctl.sv
      - rtl/jt900h_opbuf.sv
      - rtl/jt900h_idxaddr.sv
      - rtl/jt900h_idx_top.sv
  - target: simulation
    files:
      - sim/jt900h_prog_ram.sv
      - sim/jt900h_idx_tb.sv

// File: sim/jt900h_idx_tb.sv
//##################################################
// jt900h operand address path testbench
// random programs, reference model and assertions
// on every address result
//##################################################

`timescale 1ns/1ps

module jt900h_idx_tb import jt900h_pkg::*; ();

logic              clk;
logic              rst_n;
logic              cen;
logic              pc_we;
logic [ADDR_W-1:0] pc_din;
logic [ADDR_W-1:0] ram_addr;
logic [15:0]       ram_dout;
reg_wr_t           reg_wr;
logic              idx_ok;
idx_res_t          idx_res;

logic              force_cen;
logic              timed_out;
logic [31:0]       lfsr;
logic [ADDR_W-1:0] model_regs [NREGS];
idx_res_t          exp_mem [1024];
idx_res_t          exp_head;
int                exp_rd;
int                exp_wr;
int                wpos;
int                errors;
int                failed;
string             cur_test;

jt900h_idx_top u_dut (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .cen      ( cen      ),
    .pc_we    ( pc_we    ),
    .pc_din   ( pc_din   ),
    .ram_addr ( ram_addr ),
    .ram_dout ( ram_dout ),
    .reg_wr   ( reg_wr   ),
    .idx_ok   ( idx_ok   ),
    .idx_res  ( idx_res  )
);

jt900h_prog_ram u_ram (
    .clk  ( clk      ),
    .cen  ( cen      ),
    .addr ( ram_addr ),
    .dout ( ram_dout )
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// fibonacci LFSR, taps 32 22 2 1
function automatic logic step_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], step_bit()};
    end
    return r;
endfunction

always @(posedge clk) begin
    cen <= force_cen | step_bit();
end

// a result is taken on the cen edge that ends its strobe
assign exp_head = exp_mem[exp_rd];

always @(posedge clk) begin
    if (!rst_n) begin
        exp_rd <= 0;
    end else if (cen && idx_ok) begin
        exp_rd <= exp_rd + 1;
    end
end

a_expected: assert property (
    @(posedge clk) disable iff (!rst_n)
    cen && idx_ok |-> exp_rd < exp_wr
) else begin
    errors++;
    $display("%s: address result arrived with none expected", cur_test);
end

a_result: assert property (
    @(posedge clk) disable iff (!rst_n)
    cen && idx_ok && exp_rd < exp_wr |-> idx_res == exp_head
) else begin
    errors++;
    $display("Error %s expected %h actual %h", cur_test, $sampled(exp_head),
             $sampled(idx_res));
end

task automatic put_byte(input logic [7:0] b);
    logic [15:0] w;
    w = u_ram.mem[wpos >> 1];
    if (wpos % 2 == 0) begin
        w[7:0] = b;
    end else begin
        w[15:8] = b;
    end
    u_ram.mem[wpos >> 1] = w;
    wpos++;
endtask

// writes one instruction and queues the result the mode rules give
task automatic emit(input logic [2:0] mode, input logic [2:0] rsel,
                    input logic [1:0] step, input logic [23:0] opnd);
    idx_res_t r;
    r.mode = mode;
    r.len  = 3'd1;
    r.addr = model_regs[rsel];
    put_byte({mode, rsel, step});
    case (mode)
        MODE_RPINC: begin
            model_regs[rsel] += ADDR_W'((step == 2'd0) ? 1 : (step == 2'd1) ? 2 : 4);
        end
        MODE_RDISP: begin
            put_byte(opnd[7:0]);
            r.addr = model_regs[rsel] + {{16{opnd[7]}}, opnd[7:0]};
            r.len  = 3'd2;
        end
        MODE_ABS16: begin
            put_byte(opnd[7:0]);
            put_byte(opnd[15:8]);
            r.addr = {8'h00, opnd[15:0]};
            r.len  = 3'd3;
        end
        MODE_ABS24: begin
            put_byte(opnd[7:0]);
            put_byte(opnd[15:8]);
            put_byte(opnd[23:16]);
            r.addr = opnd;
            r.len  = 3'd4;
        end
        default: ;
    endcase
    if (mode >= MODE_RIND && mode <= MODE_ABS24) begin
        exp_mem[exp_wr] = r;
        exp_wr++;
    end
endtask

task automatic emit_random(input bit no_inc);
    logic [2:0] m;
    logic [1:0] s;
    m = 3'(rand_bits(3));
    s = 2'(rand_bits(2));
    if (no_inc && m == MODE_RPINC) begin
        m = MODE_RIND;
    end
    emit(m, 3'(rand_bits(3)), (s == 2'd3) ? 2'd2 : s, 24'(rand_bits(24)));
endtask

task automatic load_regs();
    @(negedge clk);
    force_cen = 1'b1;
    for (int i = 0; i < NREGS; i++) begin
        model_regs[i] = 24'(rand_bits(24));
    end
    for (int i = 0; i < NREGS; i++) begin
        @(posedge clk);
        reg_wr <= {1'b1, 3'(i), model_regs[i]};
    end
    @(posedge clk);
    reg_wr.we <= 1'b0;
    @(negedge clk);
    force_cen = 1'b0;
endtask

// jump, then anything still expected from the old stream is dropped
task automatic redirect(input int base);
    logic saved;
    @(negedge clk);
    saved     = force_cen;
    force_cen = 1'b1;
    @(posedge clk);
    pc_we  <= 1'b1;
    pc_din <= ADDR_W'(base);
    @(posedge clk);
    pc_we <= 1'b0;
    @(negedge clk);
    exp_wr    = exp_rd;
    force_cen = saved;
    wpos      = base;
endtask

task automatic wait_results(input int target);
    int n;
    n = 0;
    while (!timed_out && exp_rd < target) begin
        @(posedge clk);
        n++;
        if (n > 20000) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout in %s: %0d of %0d results seen", cur_test, exp_rd, target);
        end
    end
endtask

task automatic finish_test(input int err_start);
    wait_results(exp_wr);
    repeat (20) @(posedge clk);
    if (errors == err_start) begin
        $display("test %s: ok", cur_test);
    end else begin
        failed++;
        $display("test %s: failed with %0d errors", cur_test, errors - err_start);
    end
endtask

initial begin
    int e;
    logic [23:0] v;
    rst_n     = 1'b0;
    cen       = 1'b0;
    pc_we     = 1'b0;
    pc_din    = '0;
    reg_wr    = '0;
    force_cen = 1'b0;
    timed_out = 1'b0;
    lfsr      = 32'h326f1871;
    exp_wr    = 0;
    errors    = 0;
    failed    = 0;
    cur_test  = "reset";
    for (int i = 0; i < NREGS; i++) begin
        model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    cur_test = "reg_disp";
    e = errors;
    load_regs();
    redirect(16'h0800);
    for (int i = 0; i < NREGS; i++) begin
        emit(MODE_RIND, 3'(i), 2'd0, 24'h0);
    end
    emit(MODE_RDISP, 3'd1, 2'd0, 24'h80);
    emit(MODE_RDISP, 3'd2, 2'd0, 24'hff);
    emit(MODE_RDISP, 3'd3, 2'd0, 24'h7f);
    for (int i = 0; i < 8; i++) begin
        emit(MODE_RDISP, 3'(rand_bits(3)), 2'd0, 24'(rand_bits(8)));
    end
    finish_test(e);

    // the one-byte lead puts operands across word boundaries
    cur_test = "absolute";
    e = errors;
    redirect(16'h1000);
    emit(MODE_RIND, 3'd0, 2'd0, 24'h0);
    for (int i = 0; i < 6; i++) begin
        emit(MODE_ABS16, 3'd0, 2'd0, 24'(rand_bits(24)));
        emit(MODE_ABS24, 3'd0, 2'd0, 24'(rand_bits(24)));
    end
    finish_test(e);

    cur_test = "post_inc";
    e = errors;
    redirect(16'h1800);
    for (int s = 0; s < 3; s++) begin
        emit(MODE_RPINC, 3'd2, 2'(s), 24'h0);
        emit(MODE_RIND, 3'd2, 2'd0, 24'h0);
    end
    finish_test(e);

    cur_test = "stream";
    e = errors;
    load_regs();
    redirect(16'h2000);
    for (int i = 0; i < 200; i++) begin
        emit_random(1'b0);
    end
    finish_test(e);

    // post-increments stay out of the abandoned stream
    cur_test = "redirect";
    e = errors;
    redirect(16'h2800);
    for (int i = 0; i < 60; i++) begin
        emit_random(1'b1);
    end
    wait_results(exp_rd + 3);
    redirect(16'h3000);
    for (int i = 0; i < 30; i++) begin
        emit_random(1'b0);
    end
    finish_test(e);

    // with cen held high the first word is read on the first edge after the jump,
    // pushed on the second and the post-increment is taken on the third
    cur_test = "write_collision";
    e = errors;
    @(negedge clk);
    force_cen = 1'b1;
    v = 24'(rand_bits(24));
    redirect(16'h3800);
    emit(MODE_RPINC, 3'd3, 2'd1, 24'h0);
    model_regs[3] = v;
    emit(MODE_ABS16, 3'd0, 2'd0, 24'(rand_bits(24)));
    emit(MODE_RIND, 3'd3, 2'd0, 24'h0);
    // single load, sampled on the same edge as the post-increment
    repeat (2) @(posedge clk);
    reg_wr <= {1'b1, 3'd3, v};
    @(posedge clk);
    reg_wr.we <= 1'b0;
    @(negedge clk);
    force_cen = 1'b0;
    finish_test(e);

    $display("tests 6, failed %0d, errors %0d", failed, errors);
    if (errors == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

// File: sim/jt900h_prog_ram.sv
//##################################################
// jt900h program RAM model
// 16-bit words, read data one cen cycle after the
// address, contents written by the testbench
//##################################################

`timescale 1ns/1ps

module jt900h_prog_ram import jt900h_pkg::*; (
    input  logic              clk,
    input  logic              cen,
    input  logic [ADDR_W-1:0] addr,
    output logic [15:0]       dout
);

// 8k words, eight program regions of 2 kB each
localparam int RAM_AW = 13;

logic [15:0] mem [2**RAM_AW];

// empty program space decodes as stray bytes
initial begin
    for (int i = 0; i < 2**RAM_AW; i++) begin
        mem[i] = 16'h0000;
    end
    dout = 16'h0000;
end

always @(posedge clk) begin
    if (cen) begin
        dout <= mem[addr[RAM_AW:1]];
    end
end

endmodule

// File: rtl/jt900h_idx_top.sv
//##################################################
// jt900h operand address path
// fetch, prefetch queue and indexed addresser
//##################################################

`timescale 1ns/1ps

module jt900h_idx_top import jt900h_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    // jump
    input  logic              pc_we,
    input  logic [ADDR_W-1:0] pc_din,

    // program RAM
    output logic [ADDR_W-1:0] ram_addr,
    input  logic [15:0]       ram_dout,

    input  reg_wr_t           reg_wr,

    output logic              idx_ok,
    output idx_res_t          idx_res
);

// fetch to queue
logic        push;
logic [15:0] push_data;
logic [3:0]  free;

// queue to addresser
logic [31:0] win;
logic [3:0]  count;
logic        pop;
logic [2:0]  pop_n;

jt900h_ramctl u_ramctl (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .pc_we      ( pc_we     ),
    .pc_din     ( pc_din    ),
    .free       ( free      ),
    .ram_addr   ( ram_addr  ),
    .ram_dout   ( ram_dout  ),
    .push       ( push      ),
    .push_data  ( push_data )
);

// a jump empties the queue
jt900h_opbuf u_opbuf (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .flush      ( pc_we     ),
    .push       ( push      ),
    .push_data  ( push_data ),
    .pop        ( pop       ),
    .pop_n      ( pop_n     ),
    .win        ( win       ),
    .count      ( count     ),
    .free       ( free      )
);

jt900h_idxaddr u_idxaddr (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .flush      ( pc_we     ),
    .win        ( win       ),
    .count      ( count     ),
    .pop        ( pop       ),
    .pop_n      ( pop_n     ),
    .reg_wr     ( reg_wr    ),
    .idx_ok     ( idx_ok    ),
    .idx_res    ( idx_res   )
);

endmodule

// File: rtl/jt900h_idxaddr.sv
//##################################################
// jt900h indexed memory addresser
// decodes addressing bytes from the prefetch window,
// keeps the index registers, emits 24-bit addresses
//##################################################

`timescale 1ns/1ps

module jt900h_idxaddr import jt900h_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    input  logic        flush,

    // prefetch window
    input  logic [31:0] win,
    input  logic [3:0]  count,
    output logic        pop,
    output logic [2:0]  pop_n,

    // index register load
    input  reg_wr_t     reg_wr,

    output logic        idx_ok,
    output idx_res_t    idx_res
);

logic [ADDR_W-1:0]    regs [NREGS];

idx_mode_u            mbyte;
logic [MODE_W-1:0]    mode;
logic [REG_SEL_W-1:0] rsel;
logic [ADDR_W-1:0]    rval;
logic [ADDR_W-1:0]    step_val;
logic [ADDR_W-1:0]    ea;
logic [2:0]           need_len;
logic                 known;
logic                 accept;

assign mbyte = win[7:0];

// the code is at the same place in both views
assign mode  = mbyte.abs_view.mode;
assign rsel  = mbyte.reg_view.rsel;
assign rval  = regs[rsel];

// bytes needed, mode byte included
always_comb begin
    known = 1'b1;
    case (mode)
        MODE_RIND, MODE_RPINC: begin
            need_len = 3'd1;
        end
        MODE_RDISP: begin
            need_len = 3'd2;
        end
        MODE_ABS16: begin
            need_len = 3'd3;
        end
        MODE_ABS24: begin
            need_len = 3'd4;
        end
        default: begin
            // skip the stray byte
            need_len = 3'd1;
            known    = 1'b0;
        end
    endcase
end

// step code 3 is reserved and acts as 4
always_comb begin
    case (mbyte.reg_view.step)
        2'd0:    step_val = ADDR_W'(1);
        2'd1:    step_val = ADDR_W'(2);
        default: step_val = ADDR_W'(4);
    endcase
end

// operands follow the mode byte little-endian
always_comb begin
    case (mode)
        MODE_RDISP: ea = rval + {{(ADDR_W-8){win[15]}}, win[15:8]};
        MODE_ABS16: ea = {{(ADDR_W-16){1'b0}}, win[23:8]};
        MODE_ABS24: ea = win[31:8];
        default:    ea = rval;
    endcase
end

// nothing is taken while the queue is being flushed
assign accept = cen & ~flush & ({1'b0, need_len} <= count);
assign pop    = accept;
assign pop_n  = need_len;

// index registers
always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
        end
    end else if (cen) begin
        if (accept && mode == MODE_RPINC) begin
            regs[rsel] <= rval + step_val;
        end
        // an external load overrides a post-increment to the same register
        if (reg_wr.we) begin
            regs[reg_wr.sel] <= reg_wr.data;
        end
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        idx_ok <= 1'b0;
    end else if (cen) begin
        idx_ok <= accept & known;
    end
end

// result payload
always_ff @(posedge clk) begin
    if (cen && accept) begin
        idx_res.addr <= ea;
        idx_res.mode <= mode;
        idx_res.len  <= need_len;
    end
end

// a jump must not let an old instruction complete
a_no_ok_after_flush: assert property (
    @(posedge clk) disable iff (!rst_n)
    cen && flush |=> !idx_ok
) else $error("address result issued right after a redirect");

endmodule

// File: rtl/jt900h_opbuf.sv
//##################################################
// jt900h opcode prefetch queue
// byte FIFO with a four-byte lookahead window and a
// variable length pop
//##################################################

`timescale 1ns/1ps

module jt900h_opbuf import jt900h_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    input  logic        flush,

    // from fetch, low byte first
    input  logic        push,
    input  logic [15:0] push_data,

    // from the addresser
    input  logic        pop,
    input  logic [2:0]  pop_n,

    output logic [31:0] win,
    output logic [3:0]  count,
    output logic [3:0]  free
);

logic [7:0]           mem [BUF_DEPTH];
logic [BUF_PTR_W-1:0] rd_ptr;
logic [BUF_PTR_W-1:0] wr_ptr;
logic [3:0]           push_cnt;
logic [3:0]           pop_cnt;

assign push_cnt = push ? 4'd2 : 4'd0;
assign pop_cnt  = pop ? {1'b0, pop_n} : 4'd0;
assign free     = 4'(BUF_DEPTH) - count;

// byte 0 is the oldest one, pointers wrap on their own
always_comb begin
    for (int i = 0; i < 4; i++) begin
        win[8*i +: 8] = mem[rd_ptr + BUF_PTR_W'(i)];
    end
end

// storage
always_ff @(posedge clk) begin
    if (cen && push && !flush) begin
        mem[wr_ptr]                  <= push_data[7:0];
        mem[wr_ptr + BUF_PTR_W'(1)]  <= push_data[15:8];
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
    end else if (cen) begin
        if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + BUF_PTR_W'(2);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + BUF_PTR_W'(pop_n);
            end
            count <= count + push_cnt - pop_cnt;
        end
    end
end

// addresser only takes bytes that are really queued
a_pop_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    cen && pop |-> {1'b0, pop_n} <= count
) else $error("pop of %0d bytes with only %0d queued", pop_n, count);

endmodule

// File: rtl/jt900h_ramctl.sv
//##################################################
// jt900h program fetch
// reads 16-bit words from program RAM at the fetch
// address and pushes them into the prefetch queue
//##################################################

`timescale 1ns/1ps

module jt900h_ramctl import jt900h_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    // jump from outside
    input  logic              pc_we,
    input  logic [ADDR_W-1:0] pc_din,

    // free bytes in the queue, not counting the word in flight
    input  logic [3:0]        free,

    // program RAM
    output logic [ADDR_W-1:0] ram_addr,
    input  logic [15:0]       ram_dout,

    // to the prefetch queue
    output logic              push,
    output logic [15:0]       push_data
);

logic [ADDR_W-1:0] pc;
logic              inflight;
logic              issue;

// an odd target fetches from the word that holds it
assign ram_addr  = {pc[ADDR_W-1:1], 1'b0};

// RAM data is valid the cen cycle after the read
assign push      = inflight & ~pc_we;
assign push_data = ram_dout;

// room check includes the word that lands this cycle
always_comb begin
    if (pc_we) begin
        issue = 1'b0;
    end else if (inflight) begin
        issue = free >= 4'd4;
    end else begin
        issue = free >= 4'd2;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        pc       <= '0;
        inflight <= 1'b0;
    end else if (cen) begin
        if (pc_we) begin
            // redirect drops the outstanding read
            pc       <= pc_din;
            inflight <= 1'b0;
        end else begin
            inflight <= issue;
            if (issue) begin
                pc <= pc + ADDR_W'(2);
            end
        end
    end
end

// the queue must always have space for a returning word
a_push_room: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> free >= 4'd2
) else $error("fetch pushed a word into a full prefetch queue");

endmodule

// File: rtl/jt900h_pkg.sv
//##################################################
// jt900h indexed addressing package
// widths, mode codes and the structs shared by the
// fetch, prefetch and addresser blocks
//##################################################

package jt900h_pkg;

    // address and queue sizes
    localparam int ADDR_W    = 24;
    localparam int BUF_DEPTH = 8;
    localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

    // index register bank
    localparam int NREGS     = 8;
    localparam int REG_SEL_W = $clog2(NREGS);

    // mode code in the top bits of the mode byte
    localparam int MODE_W = 3;

    // codes 0, 6 and 7 are undefined and get skipped as one byte
    localparam logic [MODE_W-1:0] MODE_RIND  = 3'd1;
    localparam logic [MODE_W-1:0] MODE_RDISP = 3'd2;
    localparam logic [MODE_W-1:0] MODE_RPINC = 3'd3;
    localparam logic [MODE_W-1:0] MODE_ABS16 = 3'd4;
    localparam logic [MODE_W-1:0] MODE_ABS24 = 3'd5;

    // register modes: code, index register, post-increment step
    typedef struct packed {
        logic [MODE_W-1:0]    mode;
        logic [REG_SEL_W-1:0] rsel;
        // 0 -> 1, 1 -> 2, 2 -> 4
        logic [1:0]           step;
    } idx_mode_reg_t;

    // absolute modes carry the operand in the following bytes
    typedef struct packed {
        logic [MODE_W-1:0] mode;
        logic [4:0]        rsvd;
    } idx_mode_abs_t;

    typedef union packed {
        idx_mode_reg_t reg_view;
        idx_mode_abs_t abs_view;
    } idx_mode_u;

    // one addressing result
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [MODE_W-1:0] mode;
        // bytes taken from the queue, 1 to 4
        logic [2:0]        len;
    } idx_res_t;

    // external index register load
    typedef struct packed {
        logic                 we;
        logic [REG_SEL_W-1:0] sel;
        logic [ADDR_W-1:0]    data;
    } reg_wr_t;

endpackage
